// File: include/ob_cfg.svh
// Order book sizing macros, included by the package and by the testbench
`ifndef OB_CFG_SVH
`define OB_CFG_SVH

// Order identifier width
`define OB_UID_W 8

// Plain binary price
`define OB_PRICE_W 16

// Quantity per order
`define OB_QTY_W 16

// Entries held in each of the bid and ask limit tables
`define OB_TABLE_DEPTH 4

// Entries in the command and response FIFOs
`define OB_FIFO_DEPTH 4

`endif

// File: logic/ob_pkg.sv
// Shared order book types for commands, responses, table entries and match results
`default_nettype none

`include "ob_cfg.svh"

package ob_pkg;

  typedef logic [`OB_UID_W-1:0]   uid_t;
  typedef logic [`OB_PRICE_W-1:0] price_t;
  typedef logic [`OB_QTY_W-1:0]   quantity_t;

  typedef enum logic [2:0] {
    Op_Nop       = 3'd0,
    Op_QryBidAsk = 3'd1,
    Op_BuyLimit  = 3'd2,
    Op_SellLimit = 3'd3,
    Op_PopTopBid = 3'd4,
    Op_PopTopAsk = 3'd5
  } opcode_t;

  typedef enum logic [1:0] {
    S_Okay   = 2'd0,
    S_Bad    = 2'd1,
    S_BadPop = 2'd2,
    S_Reject = 2'd3
  } status_t;

  // One resting order
  typedef struct packed {
    uid_t      uid;
    price_t    price;
    quantity_t quantity;
  } table_t;

  typedef struct packed {
    opcode_t   opcode;
    uid_t      uid;
    price_t    price;
    quantity_t quantity;
  } cmd_t;

  // Widest result, sets the union width
  typedef struct packed {
    uid_t      uid;
    price_t    price;
    quantity_t quantity;
  } result_poptop_t;

  localparam int RESULT_W = $bits(result_poptop_t);

  typedef struct packed {
    price_t                                bid;
    price_t                                ask;
    logic [RESULT_W-2*`OB_PRICE_W-1:0]     padding;
  } result_qrybidask_t;

  typedef struct packed {
    uid_t                                       bid_uid;
    uid_t                                       ask_uid;
    quantity_t                                  quantity;
    logic [RESULT_W-2*`OB_UID_W-`OB_QTY_W-1:0]  padding;
  } result_trade_t;

  typedef union packed {
    result_qrybidask_t qrybidask;
    result_poptop_t    poptop;
    result_trade_t     trade;
  } result_t;

  typedef struct packed {
    uid_t    uid;
    status_t status;
    result_t result;
  } rsp_t;

  // Matcher verdict for the current bid and ask heads
  typedef struct packed {
    logic      bid_consumed;
    logic      ask_consumed;
    quantity_t remainder;
    quantity_t quantity;
    uid_t      bid_uid;
    uid_t      ask_uid;
  } search_result_t;

endpackage

`default_nettype wire

// File: logic/ob_fifo.sv
// Synchronous valid/ready FIFO for any payload type, used for commands and responses
`timescale 1ns/100ps
`default_nettype none

`include "ob_cfg.svh"

module ob_fifo #(
  parameter type T = ob_pkg::cmd_t
) (
    input  wire logic clk
  , input  wire logic rst_n
  // Write side
  , input  wire logic in_vld
  , output logic      in_rdy
  , input  wire T     in_data
  // Read side
  , output logic      out_vld
  , input  wire logic out_rdy
  , output T          out_data
);

  localparam int DEPTH = `OB_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = PTR_W + 1;

  // Payload storage
  T                 mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // Back-pressure when full
  assign in_rdy   = (count != CNT_W'(DEPTH));
  assign out_vld  = (count != '0);
  assign out_data = mem[rd_ptr];

  assign push = in_vld & in_rdy;
  assign pop  = out_vld & out_rdy;

  always_ff @(posedge clk) begin : ptr_PROC
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      // Wrap at the last slot, depth need not be a power of two
      if (push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      // Push and pop together leave the count unchanged
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk) begin : mem_PROC
    if (push)
      mem[wr_ptr] <= in_data;
  end

endmodule

`default_nettype wire

// File: logic/ob_limit_table.sv
// Price-sorted limit order table with its best entry at slot 0, one instance per side
`timescale 1ns/100ps
`default_nettype none

`include "ob_cfg.svh"

module ob_limit_table #(
  // 1 for bids (highest first), 0 for asks (lowest first)
  parameter bit IS_BID = 1'b1
) (
    input  wire logic              clk
  , input  wire logic              rst_n
  // Insert in price order
  , input  wire logic              insert
  , input  wire ob_pkg::table_t    insert_entry
  // Discard head
  , input  wire logic              pop
  // Rewrite head quantity after a partial fill
  , input  wire logic              update_vld
  , input  wire ob_pkg::quantity_t update_qty
  // Best entry and status
  , output logic                   head_vld
  , output ob_pkg::table_t         head
  , output logic                   full
);

  import ob_pkg::*;

  localparam int DEPTH = `OB_TABLE_DEPTH;

  table_t           entry   [DEPTH];
  table_t           entry_w [DEPTH];
  logic [DEPTH-1:0] vld;
  logic [DEPTH-1:0] vld_w;

  // Slots the new order outranks
  logic [DEPTH-1:0] beats;
  // Slots that take their upper neighbour on insert
  logic [DEPTH-1:0] shift;

  // Valid entries stay packed from slot 0
  assign head_vld = vld[0];
  assign head     = entry[0];
  assign full     = vld[DEPTH-1];

  always_comb begin : beats_PROC
    for (int i = 0; i < DEPTH; i++) begin
      // Strict compare, equal prices queue behind
      if (IS_BID)
        beats[i] = ~vld[i] | (insert_entry.price > entry[i].price);
      else
        beats[i] = ~vld[i] | (insert_entry.price < entry[i].price);
    end
  end

  // Thermometer code, so the slot below the first hit shifts and onwards
  assign shift = {beats[DEPTH-2:0], 1'b0};

  always_comb begin : next_PROC
    for (int i = 0; i < DEPTH; i++) begin
      entry_w[i] = entry[i];
    end
    vld_w = vld;

    if (insert && !full) begin
      for (int i = 1; i < DEPTH; i++) begin
        if (shift[i]) begin
          // Worse entries move down one slot
          entry_w[i] = entry[i-1];
          vld_w[i]   = vld[i-1];
        end else if (beats[i]) begin
          entry_w[i] = insert_entry;
          vld_w[i]   = 1'b1;
        end
      end
      // New best
      if (beats[0]) begin
        entry_w[0] = insert_entry;
        vld_w[0]   = 1'b1;
      end
    end else if (pop) begin
      // Everything moves up, tail frees
      for (int i = 0; i < DEPTH-1; i++) begin
        entry_w[i] = entry[i+1];
        vld_w[i]   = vld[i+1];
      end
      vld_w[DEPTH-1] = 1'b0;
    end else if (update_vld) begin
      entry_w[0].quantity = update_qty;
    end
  end

  always_ff @(posedge clk) begin : vld_PROC
    if (!rst_n)
      vld <= '0;
    else
      vld <= vld_w;
  end

  always_ff @(posedge clk) begin : entry_PROC
    for (int i = 0; i < DEPTH; i++) begin
      entry[i] <= entry_w[i];
    end
  end

endmodule

`default_nettype wire

// File: logic/ob_match.sv
// Registered crossing check between bid and ask heads, queried by the controller
`timescale 1ns/100ps
`default_nettype none

module ob_match (
    input  wire logic           clk
  , input  wire logic           rst_n
  // Table heads
  , input  wire logic           bid_vld
  , input  wire ob_pkg::table_t bid
  , input  wire logic           ask_vld
  , input  wire ob_pkg::table_t ask
  // Query pulse, verdict one cycle later
  , input  wire logic           trade_qry
  , output logic                trade_vld_r
  , output ob_pkg::search_result_t trade_r
);

  import ob_pkg::*;

  logic           crosses;
  logic           bid_le;
  search_result_t sr;

  always_comb begin : cmp_PROC
    // Bid meets or beats ask
    crosses = bid_vld & ask_vld & (bid.price >= ask.price);
    bid_le  = (bid.quantity <= ask.quantity);

    sr.quantity     = bid_le ? bid.quantity : ask.quantity;
    // Both consumed on equal quantities
    sr.bid_consumed = (bid.quantity == sr.quantity);
    sr.ask_consumed = (ask.quantity == sr.quantity);
    sr.remainder    = bid_le ? ask.quantity - bid.quantity : bid.quantity - ask.quantity;
    sr.bid_uid      = bid.uid;
    sr.ask_uid      = ask.uid;
  end

  // Verdict holds until the next query, so a stalled controller still sees it
  always_ff @(posedge clk) begin : vld_PROC
    if (!rst_n)
      trade_vld_r <= 1'b0;
    else if (trade_qry)
      trade_vld_r <= crosses;
  end

  always_ff @(posedge clk) begin : res_PROC
    if (trade_qry)
      trade_r <= sr;
  end

endmodule

`default_nettype wire

// File: logic/ob_cntrl.sv
// Order book controller FSM, decodes commands, drives both tables and emits responses
`timescale 1ns/100ps
`default_nettype none

module ob_cntrl (
    input  wire logic                   clk
  , input  wire logic                   rst_n
  // Command FIFO head
  , input  wire logic                   cmd_head_vld
  , input  wire ob_pkg::cmd_t           cmd_head
  , output logic                        cmd_pop
  // Response FIFO
  , input  wire logic                   rsp_full
  , output logic                        rsp_push
  , output ob_pkg::rsp_t                rsp_data
  // Bid table
  , output logic                        bid_insert
  , output ob_pkg::table_t              bid_insert_entry
  , output logic                        bid_pop
  , output logic                        bid_update_vld
  , output ob_pkg::quantity_t           bid_update_qty
  , input  wire logic                   bid_head_vld
  , input  wire ob_pkg::table_t         bid_head
  , input  wire logic                   bid_full
  // Ask table
  , output logic                        ask_insert
  , output ob_pkg::table_t              ask_insert_entry
  , output logic                        ask_pop
  , output logic                        ask_update_vld
  , output ob_pkg::quantity_t           ask_update_qty
  , input  wire logic                   ask_head_vld
  , input  wire ob_pkg::table_t         ask_head
  , input  wire logic                   ask_full
  // Matcher
  , output logic                        trade_qry
  , input  wire logic                   trade_vld_r
  , input  wire ob_pkg::search_result_t trade_r
);

  import ob_pkg::*;

  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    ISSUE_QRY = 2'd1,  // Heads settled, ask matcher
    EXECUTE   = 2'd2   // Act on the verdict
  } state_t;

  state_t state_r;
  state_t state_w;
  table_t new_entry;

  // Same order image goes to whichever side the opcode selects
  assign new_entry        = '{uid: cmd_head.uid, price: cmd_head.price,
                              quantity: cmd_head.quantity};
  assign bid_insert_entry = new_entry;
  assign ask_insert_entry = new_entry;
  // Surviving head keeps the remainder
  assign bid_update_qty   = trade_r.remainder;
  assign ask_update_qty   = trade_r.remainder;

  always_comb begin : fsm_PROC
    state_w        = state_r;
    cmd_pop        = 1'b0;
    rsp_push       = 1'b0;
    rsp_data       = '0;
    bid_insert     = 1'b0;
    bid_pop        = 1'b0;
    bid_update_vld = 1'b0;
    ask_insert     = 1'b0;
    ask_pop        = 1'b0;
    ask_update_vld = 1'b0;
    trade_qry      = 1'b0;

    case (state_r)
      IDLE: begin
        // Every command answers once, so wait for response room
        if (cmd_head_vld && !rsp_full) begin
          cmd_pop         = 1'b1;
          rsp_push        = 1'b1;
          rsp_data.uid    = cmd_head.uid;
          rsp_data.status = S_Okay;
          case (cmd_head.opcode)
            Op_Nop: begin
            end
            Op_QryBidAsk: begin
              rsp_data.result.qrybidask.bid = bid_head.price;
              rsp_data.result.qrybidask.ask = ask_head.price;
              if (!(bid_head_vld && ask_head_vld))
                rsp_data.status = S_Bad;
            end
            Op_BuyLimit: begin
              // Full side rejects at once, nothing to match
              if (bid_full) begin
                rsp_data.status = S_Reject;
              end else begin
                bid_insert = 1'b1;
                state_w    = ISSUE_QRY;
              end
            end
            Op_SellLimit: begin
              if (ask_full) begin
                rsp_data.status = S_Reject;
              end else begin
                ask_insert = 1'b1;
                state_w    = ISSUE_QRY;
              end
            end
            Op_PopTopBid: begin
              bid_pop                = bid_head_vld;
              rsp_data.result.poptop = bid_head;
              if (!bid_head_vld)
                rsp_data.status = S_BadPop;
            end
            Op_PopTopAsk: begin
              ask_pop                = ask_head_vld;
              rsp_data.result.poptop = ask_head;
              if (!ask_head_vld)
                rsp_data.status = S_BadPop;
            end
            default: begin
              // Unused opcode
              rsp_data.status = S_Bad;
            end
          endcase
        end
      end

      ISSUE_QRY: begin
        trade_qry = 1'b1;
        state_w   = EXECUTE;
      end

      EXECUTE: begin
        if (!trade_vld_r) begin
          // Book no longer crosses
          state_w = IDLE;
        end else if (!rsp_full) begin
          bid_pop        = trade_r.bid_consumed;
          ask_pop        = trade_r.ask_consumed;
          bid_update_vld = ~trade_r.bid_consumed;
          ask_update_vld = ~trade_r.ask_consumed;

          // Trades carry no originator
          rsp_push                       = 1'b1;
          rsp_data.uid                   = '1;
          rsp_data.status                = S_Okay;
          rsp_data.result.trade.bid_uid  = trade_r.bid_uid;
          rsp_data.result.trade.ask_uid  = trade_r.ask_uid;
          rsp_data.result.trade.quantity = trade_r.quantity;

          // Look again at the new heads
          state_w = ISSUE_QRY;
        end
      end

      default: state_w = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin : state_PROC
    if (!rst_n)
      state_r <= IDLE;
    else
      state_r <= state_w;
  end

endmodule

`default_nettype wire

// File: logic/ob_top.sv
// Order book top level joining the FIFOs, both limit tables, the matcher and the controller
`timescale 1ns/100ps
`default_nettype none

module ob_top (
    input  wire logic         clk
  , input  wire logic         rst_n
  // Command ingress
  , input  wire logic         cmd_vld
  , input  wire ob_pkg::cmd_t cmd
  , output logic              cmd_accept
  // Response egress
  , output logic              rsp_vld
  , output ob_pkg::rsp_t      rsp
  , input  wire logic         rsp_accept
);

  import ob_pkg::*;

  // Command FIFO head
  logic           cmd_head_vld;
  cmd_t           cmd_head;
  logic           cmd_pop;

  // Response FIFO tail
  logic           rsp_push;
  rsp_t           rsp_data;
  logic           rsp_in_rdy;

  // Bid side
  logic           bid_insert;
  table_t         bid_insert_entry;
  logic           bid_pop;
  logic           bid_update_vld;
  quantity_t      bid_update_qty;
  logic           bid_head_vld;
  table_t         bid_head;
  logic           bid_full;

  // Ask side
  logic           ask_insert;
  table_t         ask_insert_entry;
  logic           ask_pop;
  logic           ask_update_vld;
  quantity_t      ask_update_qty;
  logic           ask_head_vld;
  table_t         ask_head;
  logic           ask_full;

  // Matcher
  logic           trade_qry;
  logic           trade_vld_r;
  search_result_t trade_r;

  ob_fifo #(.T(cmd_t)) u_cmd_fifo (
      .clk      (clk)
    , .rst_n    (rst_n)
    , .in_vld   (cmd_vld)
    , .in_rdy   (cmd_accept)
    , .in_data  (cmd)
    , .out_vld  (cmd_head_vld)
    , .out_rdy  (cmd_pop)
    , .out_data (cmd_head)
  );

  ob_fifo #(.T(rsp_t)) u_rsp_fifo (
      .clk      (clk)
    , .rst_n    (rst_n)
    , .in_vld   (rsp_push)
    , .in_rdy   (rsp_in_rdy)
    , .in_data  (rsp_data)
    , .out_vld  (rsp_vld)
    , .out_rdy  (rsp_accept)
    , .out_data (rsp)
  );

  ob_limit_table #(.IS_BID(1'b1)) u_bid_table (
      .clk          (clk)
    , .rst_n        (rst_n)
    , .insert       (bid_insert)
    , .insert_entry (bid_insert_entry)
    , .pop          (bid_pop)
    , .update_vld   (bid_update_vld)
    , .update_qty   (bid_update_qty)
    , .head_vld     (bid_head_vld)
    , .head         (bid_head)
    , .full         (bid_full)
  );

  ob_limit_table #(.IS_BID(1'b0)) u_ask_table (
      .clk          (clk)
    , .rst_n        (rst_n)
    , .insert       (ask_insert)
    , .insert_entry (ask_insert_entry)
    , .pop          (ask_pop)
    , .update_vld   (ask_update_vld)
    , .update_qty   (ask_update_qty)
    , .head_vld     (ask_head_vld)
    , .head         (ask_head)
    , .full         (ask_full)
  );

  ob_match u_match (
      .clk         (clk)
    , .rst_n       (rst_n)
    , .bid_vld     (bid_head_vld)
    , .bid         (bid_head)
    , .ask_vld     (ask_head_vld)
    , .ask         (ask_head)
    , .trade_qry   (trade_qry)
    , .trade_vld_r (trade_vld_r)
    , .trade_r     (trade_r)
  );

  // Full is the inverse of the response FIFO ready
  ob_cntrl u_cntrl (
      .clk              (clk)
    , .rst_n            (rst_n)
    , .cmd_head_vld     (cmd_head_vld)
    , .cmd_head         (cmd_head)
    , .cmd_pop          (cmd_pop)
    , .rsp_full         (~rsp_in_rdy)
    , .rsp_push         (rsp_push)
    , .rsp_data         (rsp_data)
    , .bid_insert       (bid_insert)
    , .bid_insert_entry (bid_insert_entry)
    , .bid_pop          (bid_pop)
    , .bid_update_vld   (bid_update_vld)
    , .bid_update_qty   (bid_update_qty)
    , .bid_head_vld     (bid_head_vld)
    , .bid_head         (bid_head)
    , .bid_full         (bid_full)
    , .ask_insert       (ask_insert)
    , .ask_insert_entry (ask_insert_entry)
    , .ask_pop          (ask_pop)
    , .ask_update_vld   (ask_update_vld)
    , .ask_update_qty   (ask_update_qty)
    , .ask_head_vld     (ask_head_vld)
    , .ask_head         (ask_head)
    , .ask_full         (ask_full)
    , .trade_qry        (trade_qry)
    , .trade_vld_r      (trade_vld_r)
    , .trade_r          (trade_r)
  );

endmodule

`default_nettype wire

// File: verification/tb_ob_top.sv
// Directed testbench for ob_top, checks every response against a reference model of both tables
`timescale 1ns/100ps
`default_nettype none

`include "ob_cfg.svh"

module tb_ob_top;

  import ob_pkg::*;

  localparam int DEPTH   = `OB_TABLE_DEPTH;
  // Cycles any single wait may take
  localparam int TIMEOUT = 200;
  // Which part of the result the monitor compares
  localparam int K_NONE  = 0;
  localparam int K_QRY   = 1;
  localparam int K_POP   = 2;
  localparam int K_TRADE = 3;

  logic clk;
  logic rst_n;
  logic cmd_vld;
  cmd_t cmd;
  logic cmd_accept;
  logic rsp_vld;
  rsp_t rsp;
  logic rsp_accept;

  // Reference book, slot 0 is best
  table_t bid_q[$];
  table_t ask_q[$];
  // Responses the DUT still owes, in order
  rsp_t   exp_q[$];
  int     kind_q[$];

  string       cur_test;
  int          errors;
  int          test_err_start;
  int          tests_run;
  int          tests_failed;
  bit          timed_out;
  uid_t        next_uid;
  int unsigned seed_val;

  ob_top i_ob_top (
      .clk        (clk)
    , .rst_n      (rst_n)
    , .cmd_vld    (cmd_vld)
    , .cmd        (cmd)
    , .cmd_accept (cmd_accept)
    , .rsp_vld    (rsp_vld)
    , .rsp        (rsp)
    , .rsp_accept (rsp_accept)
  );

  // 4 ns period
  always #2 clk = ~clk;

  task automatic check_status(input status_t exp, input status_t act);
    if (exp !== act) begin
      $display("** Error %s: status expected %s, got %s", cur_test, exp.name(), act.name());
      errors++;
    end
  endtask

  task automatic check_uid(input uid_t exp, input uid_t act);
    if (exp !== act) begin
      $display("** Error %s: uid expected %02h, got %02h", cur_test, exp, act);
      errors++;
    end
  endtask

  task automatic check_poptop(input result_poptop_t exp, input result_poptop_t act);
    if (exp !== act) begin
      $display("** Error %s: pop expected %02h/%0d/%0d (uid/price/qty), got %02h/%0d/%0d",
               cur_test, exp.uid, exp.price, exp.quantity, act.uid, act.price, act.quantity);
      errors++;
    end
  endtask

  task automatic check_trade(input result_trade_t exp, input result_trade_t act);
    if (exp !== act) begin
      $display("** Error %s: trade expected %02h/%02h/%0d (bid/ask/qty), got %02h/%02h/%0d",
               cur_test, exp.bid_uid, exp.ask_uid, exp.quantity,
               act.bid_uid, act.ask_uid, act.quantity);
      errors++;
    end
  endtask

  task automatic check_qrybidask(input result_qrybidask_t exp, input result_qrybidask_t act);
    if (exp !== act) begin
      $display("** Error %s: query expected bid %0d ask %0d, got bid %0d ask %0d",
               cur_test, exp.bid, exp.ask, act.bid, act.ask);
      errors++;
    end
  endtask

  // All ones is reserved for trades
  function automatic uid_t alloc_uid();
    uid_t u;
    u = next_uid;
    next_uid++;
    if (next_uid == '1)
      next_uid = '0;
    return u;
  endfunction

  function automatic void expect_rsp(input uid_t u, input status_t s, input int kind,
                                     input result_t r);
    rsp_t e;
    e.uid    = u;
    e.status = s;
    e.result = r;
    exp_q.push_back(e);
    kind_q.push_back(kind);
  endfunction

  // Equal prices queue behind, so only a strictly better price goes ahead
  function automatic void model_insert(input bit is_bid, input table_t e);
    int pos;
    if (is_bid) begin
      pos = bid_q.size();
      for (int i = 0; i < bid_q.size(); i++) begin
        if (pos == bid_q.size() && e.price > bid_q[i].price)
          pos = i;
      end
      bid_q.insert(pos, e);
    end else begin
      pos = ask_q.size();
      for (int i = 0; i < ask_q.size(); i++) begin
        if (pos == ask_q.size() && e.price < ask_q[i].price)
          pos = i;
      end
      ask_q.insert(pos, e);
    end
  endfunction

  // One trade per crossing pair of heads
  function automatic void model_match();
    quantity_t q;
    result_t   r;
    while (bid_q.size() > 0 && ask_q.size() > 0 && bid_q[0].price >= ask_q[0].price) begin
      q = (bid_q[0].quantity < ask_q[0].quantity) ? bid_q[0].quantity : ask_q[0].quantity;
      r = '0;
      r.trade.bid_uid  = bid_q[0].uid;
      r.trade.ask_uid  = ask_q[0].uid;
      r.trade.quantity = q;
      expect_rsp('1, S_Okay, K_TRADE, r);
      // Smaller side leaves, larger keeps the remainder
      if (bid_q[0].quantity == q)
        void'(bid_q.pop_front());
      else
        bid_q[0].quantity = bid_q[0].quantity - q;
      if (ask_q[0].quantity == q)
        void'(ask_q.pop_front());
      else
        ask_q[0].quantity = ask_q[0].quantity - q;
    end
  endfunction

  function automatic void model_cmd(input cmd_t c);
    table_t  e;
    result_t r;
    r          = '0;
    e.uid      = c.uid;
    e.price    = c.price;
    e.quantity = c.quantity;
    case (c.opcode)
      Op_Nop: expect_rsp(c.uid, S_Okay, K_NONE, r);
      Op_QryBidAsk: begin
        if (bid_q.size() > 0 && ask_q.size() > 0) begin
          r.qrybidask.bid = bid_q[0].price;
          r.qrybidask.ask = ask_q[0].price;
          expect_rsp(c.uid, S_Okay, K_QRY, r);
        end else begin
          expect_rsp(c.uid, S_Bad, K_NONE, r);
        end
      end
      Op_BuyLimit, Op_SellLimit: begin
        if ((c.opcode == Op_BuyLimit ? bid_q.size() : ask_q.size()) == DEPTH) begin
          expect_rsp(c.uid, S_Reject, K_NONE, r);
        end else begin
          model_insert(c.opcode == Op_BuyLimit, e);
          expect_rsp(c.uid, S_Okay, K_NONE, r);
          model_match();
        end
      end
      Op_PopTopBid: begin
        if (bid_q.size() == 0) begin
          expect_rsp(c.uid, S_BadPop, K_NONE, r);
        end else begin
          r.poptop.uid      = bid_q[0].uid;
          r.poptop.price    = bid_q[0].price;
          r.poptop.quantity = bid_q[0].quantity;
          void'(bid_q.pop_front());
          expect_rsp(c.uid, S_Okay, K_POP, r);
        end
      end
      Op_PopTopAsk: begin
        if (ask_q.size() == 0) begin
          expect_rsp(c.uid, S_BadPop, K_NONE, r);
        end else begin
          r.poptop.uid      = ask_q[0].uid;
          r.poptop.price    = ask_q[0].price;
          r.poptop.quantity = ask_q[0].quantity;
          void'(ask_q.pop_front());
          expect_rsp(c.uid, S_Okay, K_POP, r);
        end
      end
      default: expect_rsp(c.uid, S_Bad, K_NONE, r);
    endcase
  endfunction

  // Starts and ends half a nanosecond after a rising edge
  task automatic do_cmd(input opcode_t op, input price_t p, input quantity_t q);
    cmd_t c;
    int   waited;
    if (!timed_out) begin
      c.opcode   = op;
      c.uid      = alloc_uid();
      c.price    = p;
      c.quantity = q;
      model_cmd(c);
      cmd     = c;
      cmd_vld = 1'b1;
      waited  = 0;
      @(negedge clk);
      while (!cmd_accept && waited < TIMEOUT) begin
        waited++;
        @(negedge clk);
      end
      if (!cmd_accept) begin
        $display("%s: command FIFO never accepted a command within %0d cycles",
                 cur_test, TIMEOUT);
        errors++;
        timed_out = 1'b1;
      end
      // Transfer happens on this edge
      @(posedge clk);
      #0.5;
      cmd_vld = 1'b0;
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < TIMEOUT && !timed_out) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0 && !timed_out) begin
      $display("%s: %0d responses still missing after %0d cycles",
               cur_test, exp_q.size(), TIMEOUT);
      errors++;
      timed_out = 1'b1;
    end
    @(posedge clk);
    #0.5;
  endtask

  // Empties the book through pops, which also checks what is left
  task automatic clear_book();
    while (bid_q.size() > 0 && !timed_out)
      do_cmd(Op_PopTopBid, '0, '0);
    while (ask_q.size() > 0 && !timed_out)
      do_cmd(Op_PopTopAsk, '0, '0);
    drain();
  endtask

  task automatic start_test(input string name);
    cur_test       = name;
    test_err_start = errors;
    tests_run++;
  endtask

  task automatic end_test();
    int n;
    n = errors - test_err_start;
    if (n != 0)
      tests_failed++;
    $display("%-16s %s, %0d errors", cur_test, (n == 0) ? "ok" : "FAILED", n);
  endtask

  task automatic test_nop_query();
    start_test("nop_query");
    do_cmd(Op_Nop, '0, '0);
    // Empty book
    do_cmd(Op_QryBidAsk, '0, '0);
    do_cmd(Op_BuyLimit, 16'd100, 16'd10);
    do_cmd(Op_SellLimit, 16'd120, 16'd10);
    do_cmd(Op_QryBidAsk, '0, '0);
    clear_book();
    end_test();
  endtask

  // Narrow price range makes ties likely
  task automatic test_sort_order();
    start_test("sort_order");
    for (int i = 0; i < DEPTH; i++)
      do_cmd(Op_BuyLimit, price_t'(100 + $urandom % 3), quantity_t'(1 + $urandom % 50));
    for (int i = 0; i <= DEPTH; i++)
      do_cmd(Op_PopTopBid, '0, '0);
    for (int i = 0; i < DEPTH; i++)
      do_cmd(Op_SellLimit, price_t'(200 + $urandom % 3), quantity_t'(1 + $urandom % 50));
    for (int i = 0; i <= DEPTH; i++)
      do_cmd(Op_PopTopAsk, '0, '0);
    drain();
    end_test();
  endtask

  task automatic test_cross();
    start_test("cross");
    do_cmd(Op_BuyLimit, 16'd110, 16'd5);
    do_cmd(Op_BuyLimit, 16'd108, 16'd7);
    do_cmd(Op_BuyLimit, 16'd105, 16'd4);
    // Sweeps the first bid, partly fills the second
    do_cmd(Op_SellLimit, 16'd107, 16'd10);
    do_cmd(Op_PopTopBid, '0, '0);
    do_cmd(Op_PopTopAsk, '0, '0);
    clear_book();
    end_test();
  endtask

  task automatic test_full_reject();
    start_test("full_reject");
    for (int i = 0; i < DEPTH; i++)
      do_cmd(Op_BuyLimit, price_t'(50 + i), quantity_t'(10 + i));
    // Would be the new best bid
    do_cmd(Op_BuyLimit, 16'd60, 16'd1);
    clear_book();
    for (int i = 0; i < DEPTH; i++)
      do_cmd(Op_SellLimit, price_t'(300 + i), quantity_t'(20 + i));
    do_cmd(Op_SellLimit, 16'd250, 16'd1);
    clear_book();
    end_test();
  endtask

  task automatic test_backpressure();
    int      sent;
    bit      full_seen;
    opcode_t op;
    start_test("backpressure");
    rsp_accept = 1'b0;
    sent       = 0;
    full_seen  = 1'b0;
    // Random mix with overlapping prices so some inserts trade
    while (!full_seen && sent < 4 * `OB_FIFO_DEPTH + 8 && !timed_out) begin
      op = opcode_t'($urandom % 6);
      do_cmd(op, price_t'(100 + $urandom % 8), quantity_t'(1 + $urandom % 20));
      sent++;
      full_seen = !cmd_accept;
    end
    if (!full_seen && !timed_out) begin
      $display("%s: cmd_accept never fell after %0d commands", cur_test, sent);
      errors++;
    end
    repeat (5) @(posedge clk);
    #0.5;
    rsp_accept = 1'b1;
    drain();
    clear_book();
    end_test();
  endtask

  // Compares each transfer, which completes on the following rising edge
  initial begin : monitor_PROC
    rsp_t exp;
    int   kind;
    forever begin
      @(negedge clk);
      if (rst_n && rsp_vld && rsp_accept) begin
        if (exp_q.size() == 0) begin
          $display("%s: DUT sent a response that no command asked for", cur_test);
          errors++;
        end else begin
          exp  = exp_q.pop_front();
          kind = kind_q.pop_front();
          check_uid(exp.uid, rsp.uid);
          check_status(exp.status, rsp.status);
          case (kind)
            K_QRY:   check_qrybidask(exp.result.qrybidask, rsp.result.qrybidask);
            K_POP:   check_poptop(exp.result.poptop, rsp.result.poptop);
            K_TRADE: check_trade(exp.result.trade, rsp.result.trade);
            default: begin
            end
          endcase
        end
      end
    end
  end

  initial begin : main_PROC
    clk          = 1'b0;
    rst_n        = 1'b0;
    cmd_vld      = 1'b0;
    cmd          = '0;
    rsp_accept   = 1'b1;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    next_uid     = 8'h01;
    cur_test     = "reset";
    seed_val     = $urandom(60);

    repeat (10) @(posedge clk);
    #0.5;
    rst_n = 1'b1;

    test_nop_query();
    test_sort_order();
    test_cross();
    test_full_reject();
    test_backpressure();

    // Idle window to catch stray responses
    repeat (20) @(posedge clk);
    $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
logic/ob_pkg.sv
logic/ob_fifo.sv
logic/ob_limit_table.sv
logic/ob_match.sv
logic/ob_cntrl.sv
logic/ob_top.sv
verification/tb_ob_top.sv

// File: Bender.yml
package:
  name: ob_top

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/ob_pkg.sv
      - logic/ob_fifo.sv
      - logic/ob_limit_table.sv
      - logic/ob_match.sv
      - logic/ob_cntrl.sv
      - logic/ob_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_ob_top.sv
